// ==== dmix_core.f ====
src/audio_pkg.sv
src/dac_pkg.sv
src/sample_stream_if.sv
src/sample_fifo.sv
src/frame_assembler.sv
src/i2s_dac_drv.sv
src/dmix_core.sv
verification/tb_dmix_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the dmix_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dmix_core.f \
    --top-module tb_dmix_core -Mdir obj_dir -o sim_dmix_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_dmix_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1

// ==== src/audio_pkg.sv ====
// audio sample width, sample and frame types, sample FIFO sizing
package audio_pkg;

    // PCM word width delivered by the receiver
    localparam int SAMPLE_W = 24;

    // signed two's complement PCM sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // one decoded sample with its channel tag
    // right = 1 marks the right channel, 0 the left
    typedef struct packed {
        sample_t data;
        logic    right;
    } tagged_sample_t;

    // stereo pair handed to the DAC driver
    typedef struct packed {
        sample_t left;
        sample_t right;
    } frame_t;

    // sample FIFO between receiver and frame assembler
    localparam int FIFO_DEPTH = 16;

    // address width for FIFO_DEPTH entries
    localparam int FIFO_AW = 4;

endpackage

// ==== src/dac_pkg.sv ====
// I2S timing constants for bit clock, channel slot, frame and frame request
package dac_pkg;

    // clk491520 cycles per half bit clock, bck = clk491520 / 16
    localparam int BCK_HALF = 8;

    // clk491520 cycles per bit clock period
    localparam int BIT_CYC = 2 * BCK_HALF;

    // bit clocks per channel slot
    localparam int SLOT_BITS = 32;

    // clk491520 cycles per channel slot
    localparam int SLOT_CYC = SLOT_BITS * BIT_CYC;

    // two slots per frame, 1024 cycles
    localparam int FRAME_CYC = 2 * SLOT_CYC;

    // frame counter width
    localparam int CNT_W = $clog2(FRAME_CYC);

    // next frame is requested a few cycles before the wrap
    localparam int POP_CYC = FRAME_CYC - 4;

endpackage

// ==== src/dmix_core.sv ====
// dmix_core: playback path top level, sample FIFO, frame assembler and I2S DAC driver
`timescale 1ns/1ps

module dmix_core (
    input  logic                          clk491520,
    input  logic                          rst_ip,
    input  logic                          sample_push_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] sample_data_i,
    input  logic                          sample_right_i,
    input  logic                          locked_i,
    output logic                          dac_bck_o,
    output logic                          dac_lrck_o,
    output logic                          dac_data_o,
    output logic                          overflow_o
);

    audio_pkg::tagged_sample_t push_word;
    logic                      push_gated;

    sample_if u_sample_if ();
    frame_if  u_frame_if ();

    assign push_word  = '{data: sample_data_i, right: sample_right_i};
    // samples from an unlocked source are ignored
    assign push_gated = sample_push_i && locked_i;

    sample_fifo u_sample_fifo (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .push_i     (push_gated),
        .data_i     (push_word),
        .overflow_o (overflow_o),
        .rd         (u_sample_if.fifo)
    );

    frame_assembler u_frame_assembler (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .locked_i  (locked_i),
        .src       (u_sample_if.sink),
        .dst       (u_frame_if.source)
    );

    i2s_dac_drv u_i2s_dac_drv (
        .clk491520 (clk491520),
        .rst_ip    (rst_ip),
        .src       (u_frame_if.sink),
        .bck_o     (dac_bck_o),
        .lrck_o    (dac_lrck_o),
        .data_o    (dac_data_o)
    );

endmodule

// ==== src/frame_assembler.sv ====
// frame_assembler: pops tagged samples and pairs left and right into a stereo frame
`timescale 1ns/1ps

module frame_assembler (
    input  logic     clk491520,
    input  logic     rst_ip,
    input  logic     locked_i,
    sample_if.sink   src,
    frame_if.source  dst
);

    audio_pkg::sample_t left_q;
    audio_pkg::sample_t right_q;

    logic half_q;
    logic pending_q;
    logic pop_q;
    logic ack_q;

    // lock loss empties the FIFO and drops any partial frame
    assign src.flush = !locked_i;
    assign src.pop   = pop_q;

    assign dst.ack           = ack_q;
    assign dst.valid_pending = pending_q;
    assign dst.frame         = '{left: left_q, right: right_q};

    // at most one pop per two cycles, none while a full frame waits
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= !src.empty && !pop_q && !pending_q && locked_i;
        end
    end

    always_ff @(posedge clk491520) begin
        if (pop_q && !src.word.right) begin
            left_q <= src.word.data;
        end
        if (pop_q && src.word.right && half_q) begin
            right_q <= src.word.data;
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip || src.flush) begin
            half_q    <= 1'b0;
            pending_q <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= dst.req && pending_q && !ack_q;
            // frame taken by the driver
            if (ack_q) begin
                pending_q <= 1'b0;
            end
            if (pop_q) begin
                if (!src.word.right) begin
                    // a second left simply replaces the first
                    half_q <= 1'b1;
                end else if (half_q) begin
                    half_q    <= 1'b0;
                    pending_q <= 1'b1;
                end
                // lone right is dropped
            end
        end
    end

    a_ack_after_req: assert property (@(posedge clk491520) disable iff (rst_ip)
        dst.ack |-> $past(dst.req));

endmodule

// ==== src/i2s_dac_drv.sv ====
// i2s_dac_drv: bit clock and word select generation, frame request, MSB-first I2S shift
`timescale 1ns/1ps

module i2s_dac_drv (
    input  logic    clk491520,
    input  logic    rst_ip,
    frame_if.sink   src,
    output logic    bck_o,
    output logic    lrck_o,
    output logic    data_o
);

    logic [dac_pkg::CNT_W-1:0] cnt;
    logic [dac_pkg::CNT_W-1:0] cnt_nxt;
    int                        slot_bit;
    logic                      right_slot;
    logic                      bit_edge;
    logic                      in_word;
    logic                      wrap;
    logic                      req_q;
    logic                      have_frame;
    audio_pkg::frame_t         next_frame;
    audio_pkg::sample_t        left_sr;
    audio_pkg::sample_t        right_sr;

    // frame length is a power of two, the counter wraps by itself
    assign cnt_nxt = cnt + 1'b1;
    assign wrap    = (cnt_nxt == '0);

    // position decode for the value the counter moves to
    assign right_slot = (int'(cnt_nxt) >= dac_pkg::SLOT_CYC);
    assign slot_bit   = (int'(cnt_nxt) / dac_pkg::BIT_CYC) % dac_pkg::SLOT_BITS;
    assign bit_edge   = ((int'(cnt_nxt) % dac_pkg::BIT_CYC) == 0);
    // I2S one-bit delay, sample occupies bits 1 to SAMPLE_W
    assign in_word    = (slot_bit >= 1) && (slot_bit <= audio_pkg::SAMPLE_W);

    assign src.req = req_q;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            cnt    <= '0;
            bck_o  <= 1'b0;
            lrck_o <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            cnt    <= cnt_nxt;
            bck_o  <= (int'(cnt_nxt) % dac_pkg::BIT_CYC) >= dac_pkg::BCK_HALF;
            lrck_o <= right_slot;
            req_q  <= (int'(cnt_nxt) == dac_pkg::POP_CYC);
        end
    end

    // acked frame waits here until the wrap
    always_ff @(posedge clk491520) begin
        if (src.ack && src.valid_pending) begin
            next_frame <= src.frame;
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip || wrap) begin
            have_frame <= 1'b0;
        end else if (src.ack && src.valid_pending) begin
            have_frame <= 1'b1;
        end
    end

    // shift registers cleared too, first frame after reset is silent
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            data_o   <= 1'b0;
            left_sr  <= '0;
            right_sr <= '0;
        end else if (wrap) begin
            data_o   <= 1'b0;
            left_sr  <= have_frame ? next_frame.left : '0;
            right_sr <= have_frame ? next_frame.right : '0;
        end else if (bit_edge) begin
            if (!in_word) begin
                data_o <= 1'b0;
            end else if (right_slot) begin
                data_o   <= right_sr[audio_pkg::SAMPLE_W-1];
                right_sr <= {right_sr[audio_pkg::SAMPLE_W-2:0], 1'b0};
            end else begin
                data_o  <= left_sr[audio_pkg::SAMPLE_W-1];
                left_sr <= {left_sr[audio_pkg::SAMPLE_W-2:0], 1'b0};
            end
        end
    end

    a_lrck_on_bck_low: assert property (@(posedge clk491520) disable iff (rst_ip)
        $changed(lrck_o) |-> !bck_o);

endmodule

// ==== src/sample_fifo.sv ====
// sample_fifo: synchronous FIFO of tagged samples with flush and sticky overflow
`timescale 1ns/1ps

module sample_fifo (
    input  logic                      clk491520,
    input  logic                      rst_ip,
    input  logic                      push_i,
    input  audio_pkg::tagged_sample_t data_i,
    output logic                      overflow_o,
    sample_if.fifo                    rd
);

    audio_pkg::tagged_sample_t mem [audio_pkg::FIFO_DEPTH];

    logic [audio_pkg::FIFO_AW-1:0] wr_ptr;
    logic [audio_pkg::FIFO_AW-1:0] rd_ptr;
    logic [audio_pkg::FIFO_AW:0]   count;
    logic                          full;
    logic                          do_push;
    logic                          do_pop;

    assign full     = (count == (audio_pkg::FIFO_AW + 1)'(audio_pkg::FIFO_DEPTH));
    assign rd.empty = (count == '0);
    assign rd.word  = mem[rd_ptr];

    // flush wins over both ports
    assign do_push = push_i && !full && !rd.flush;
    assign do_pop  = rd.pop && !rd.flush;

    always_ff @(posedge clk491520) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip || rd.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // dropped push, stays set until reset
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            overflow_o <= 1'b0;
        end else if (push_i && full && !rd.flush) begin
            overflow_o <= 1'b1;
        end
    end

    // the assembler must respect empty
    a_no_pop_when_empty: assert property (@(posedge clk491520) disable iff (rst_ip)
        rd.pop |-> !rd.empty);

    a_count_in_range: assert property (@(posedge clk491520) disable iff (rst_ip)
        count <= (audio_pkg::FIFO_AW + 1)'(audio_pkg::FIFO_DEPTH));

endmodule

// ==== src/sample_stream_if.sv ====
// interfaces sample_if (FIFO to assembler) and frame_if (assembler to DAC driver)
`timescale 1ns/1ps

interface sample_if;
    logic                      empty;
    logic                      pop;
    audio_pkg::tagged_sample_t word;
    logic                      flush;

    // pop only while empty is low, word consumed at that edge
    modport fifo (output empty, output word, input pop, input flush);
    modport sink (input empty, input word, output pop, output flush);
endinterface

interface frame_if;
    logic              req;
    logic              ack;
    audio_pkg::frame_t frame;
    logic              valid_pending;

    // req is a one-cycle pulse, ack comes in the following cycle or not at all
    modport source (input req, output ack, output frame, output valid_pending);
    modport sink (output req, input ack, input frame, input valid_pending);
endinterface

// ==== verification/dmix_cases.txt ====
# columns: command a b c ovf (hex), ovf is the expected overflow_o after the command
# push: a=right tag b=sample c=frame it completes or 0; burst: a=count b=first c=accepted; idle: a=frames; unlock: a=cycles b=ignored sample
idle 2 0 0 0
push 0 123456 0 0
push 1 a5a5a5 123456a5a5a5 0
push 0 7fffff 0 0
push 1 800001 7fffff800001 0
idle 3 0 0 0
push 1 0badc0 0 0
push 0 111111 0 0
push 0 222222 0 0
push 1 333333 222222333333 0
idle 4 0 0 0
burst 18 400000 12 1
idle c 0 0 1
push 0 555555 0 1
push 1 666666 0 1
unlock 28 777777 0 1
push 0 0a0a0a 0 1
push 1 0b0b0b 0a0a0a0b0b0b 1
idle 4 0 0 1

// ==== verification/tb_dmix_core.sv ====
// dmix_core testbench with clock, reset, case-file stimulus, I2S deserializer and compare tasks
`timescale 1ns/1ps

module tb_dmix_core;

    logic                           clk491520;
    logic                           rst_ip;
    logic                           sample_push_i;
    logic [audio_pkg::SAMPLE_W-1:0] sample_data_i;
    logic                           sample_right_i;
    logic                           locked_i;
    logic                           dac_bck_o;
    logic                           dac_lrck_o;
    logic                           dac_data_o;
    logic                           overflow_o;

    // frames still owed by the DUT in output order
    audio_pkg::frame_t exp_q [$];

    // deserializer state
    int                 bck_cnt = 0;
    int                 bit_idx;
    logic               in_right;
    audio_pkg::sample_t rx_left;
    audio_pkg::sample_t rx_right;

    int          fd;
    int          fields;
    string       line;
    string       cmd;
    logic [47:0] op_a;
    logic [47:0] op_b;
    logic [47:0] op_c;
    logic [47:0] op_ovf;

    dmix_core u_dmix_core (
        .clk491520      (clk491520),
        .rst_ip         (rst_ip),
        .sample_push_i  (sample_push_i),
        .sample_data_i  (sample_data_i),
        .sample_right_i (sample_right_i),
        .locked_i       (locked_i),
        .dac_bck_o      (dac_bck_o),
        .dac_lrck_o     (dac_lrck_o),
        .dac_data_o     (dac_data_o),
        .overflow_o     (overflow_o)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_frame(input audio_pkg::frame_t got, input audio_pkg::frame_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t: frame L=%h R=%h, expected L=%h R=%h",
                $time, got.left, got.right, exp.left, exp.right));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // returns at the first falling edge of clk491520 that sees lrck fallen
    task automatic wait_frame_start();
        int   n;
        logic prev;
        n    = 0;
        prev = dac_lrck_o;
        @(negedge clk491520);
        while (!(prev && !dac_lrck_o)) begin
            if (n >= 3 * dac_pkg::FRAME_CYC) begin
                stop_run("timeout: no I2S frame start seen on dac_lrck_o");
            end
            prev = dac_lrck_o;
            @(negedge clk491520);
            n++;
        end
    endtask

    task automatic push_sample(input logic right, input audio_pkg::sample_t data,
                               input audio_pkg::frame_t completes);
        int gap;
        gap = $urandom % 8;
        repeat (gap) @(negedge clk491520);
        if (completes != '0) begin
            exp_q.push_back(completes);
        end
        sample_push_i  = 1'b1;
        sample_right_i = right;
        sample_data_i  = data;
        @(negedge clk491520);
        sample_push_i = 1'b0;
    endtask

    // back to back pushes with left on even index and right on odd
    task automatic push_burst(input int count, input audio_pkg::sample_t base,
                              input int accepted);
        int                i;
        audio_pkg::frame_t f;
        wait_frame_start();
        for (i = 0; i < accepted / 2; i++) begin
            f.left  = base + 24'(2 * i);
            f.right = f.left + 24'd1;
            exp_q.push_back(f);
        end
        for (i = 0; i < count; i++) begin
            sample_push_i  = 1'b1;
            sample_right_i = i[0];
            sample_data_i  = base + 24'(i);
            @(negedge clk491520);
        end
        sample_push_i = 1'b0;
    endtask

    task automatic lose_lock(input int cycles, input audio_pkg::sample_t data);
        int i;
        // a buffered left and right pair that the flush has to discard
        sample_push_i  = 1'b1;
        sample_right_i = 1'b0;
        sample_data_i  = data;
        @(negedge clk491520);
        sample_right_i = 1'b1;
        @(negedge clk491520);
        locked_i = 1'b0;
        // these pushes must never reach the FIFO
        for (i = 0; i < cycles; i++) begin
            sample_push_i  = 1'b1;
            sample_right_i = i[0];
            sample_data_i  = data;
            @(negedge clk491520);
        end
        sample_push_i = 1'b0;
        locked_i      = 1'b1;
    endtask

    task automatic idle_frames(input int frames);
        int i;
        for (i = 0; i < frames; i++) begin
            wait_frame_start();
        end
        if (exp_q.size() != 0) begin
            stop_run($sformatf("%0d expected frames never came out", exp_q.size()));
        end
    endtask

    task automatic run_command();
        if (cmd == "push") begin
            push_sample(op_a[0], op_b[23:0], op_c);
        end else if (cmd == "burst") begin
            push_burst(op_a[31:0], op_b[23:0], op_c[31:0]);
        end else if (cmd == "unlock") begin
            lose_lock(op_a[31:0], op_b[23:0]);
        end else if (cmd == "idle") begin
            idle_frames(op_a[31:0]);
        end else begin
            stop_run({"unknown command in case file: ", cmd});
        end
    endtask

    // I2S receiver taking one bit per rising bck and 32 bits per slot
    always @(posedge dac_bck_o) begin
        bit_idx  = bck_cnt % dac_pkg::SLOT_BITS;
        in_right = ((bck_cnt / dac_pkg::SLOT_BITS) % 2) == 1;
        check_flag("dac_lrck_o", dac_lrck_o, in_right);
        if (bit_idx >= 1 && bit_idx <= audio_pkg::SAMPLE_W) begin
            if (in_right) begin
                rx_right = {rx_right[audio_pkg::SAMPLE_W-2:0], dac_data_o};
            end else begin
                rx_left = {rx_left[audio_pkg::SAMPLE_W-2:0], dac_data_o};
            end
        end else begin
            check_flag("padding bit on dac_data_o", dac_data_o, 1'b0);
        end
        // silent frames pass and anything else must be the next expected frame
        if (in_right && bit_idx == dac_pkg::SLOT_BITS - 1 && {rx_left, rx_right} != '0) begin
            if (exp_q.size() == 0) begin
                stop_run($sformatf("Fail at %0t: unexpected frame L=%h R=%h",
                    $time, rx_left, rx_right));
            end else begin
                check_frame('{left: rx_left, right: rx_right}, exp_q.pop_front());
            end
        end
        bck_cnt++;
    end

    initial begin
        clk491520 = 1'b0;
        forever #2 clk491520 = ~clk491520;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h6b903645));
        rst_ip         = 1'b1;
        sample_push_i  = 1'b0;
        sample_data_i  = '0;
        sample_right_i = 1'b0;
        locked_i       = 1'b1;
        repeat (8) @(negedge clk491520);
        check_flag("dac_bck_o in reset", dac_bck_o, 1'b0);
        check_flag("dac_lrck_o in reset", dac_lrck_o, 1'b0);
        check_flag("dac_data_o in reset", dac_data_o, 1'b0);
        check_flag("overflow_o in reset", overflow_o, 1'b0);
        rst_ip = 1'b0;
        fd = $fopen("verification/dmix_cases.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open verification/dmix_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h", cmd, op_a, op_b, op_c, op_ovf);
                if (fields != 5) begin
                    stop_run({"malformed line in case file: ", line});
                end
                run_command();
                check_flag("overflow_o", overflow_o, op_ovf[0]);
            end
        end
        $fclose(fd);
        if (exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stop_run("expected frames left over at the end of the case file");
        end
    end

endmodule
